//--- source/ppuPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PPU name table package
// Shared widths, word types, memory map and credit constants for the
// name table store, its loader queues and the tile fetcher
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package ppuPkg;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RAM geometry
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int RAM_WORDS      = 512;
    localparam int BYTES_PER_WORD = 4;

    typedef logic [8:0]  ramAddrT;   // word address
    typedef logic [31:0] ramWordT;   // byte k sits in bits 8k+7 down to 8k
    typedef logic [3:0]  byteEnT;    // bit k enables byte k
    typedef logic [1:0]  laneT;      // byte lane inside a word

    // name bytes in words 0 to 239, attribute bytes in words 256 to 271
    localparam ramAddrT NAME_BASE = 9'd0;
    localparam ramAddrT ATTR_BASE = 9'd256;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tile stream
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [7:0] tileIdxT;
    typedef logic [1:0] paletteT;
    typedef logic [4:0] tileColT;    // 0 to 31
    typedef logic [4:0] tileRowT;    // 0 to 29

    typedef enum logic {
        idle,
        walk
    } fetchStateT;

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // credits
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int LOADER_CREDITS = 4;   // also the depth of each loader queue
    localparam int TILE_CREDITS   = 4;

    localparam int QUEUE_PTR_W = $clog2(LOADER_CREDITS);

    typedef logic [QUEUE_PTR_W-1:0]            queuePtrT;
    typedef logic [QUEUE_PTR_W:0]              queueCntT;
    typedef logic [$clog2(TILE_CREDITS+1)-1:0] creditCntT;

endpackage

//--- source/nameTableRam.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Name table RAM
// 512 x 32 block memory with one byte-masked write port and three
// registered read ports for the CPU, the name fetch and the attribute fetch
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module nameTableRam (
    input  logic            clk_sel,
    input  ppuPkg::byteEnT  we,
    input  ppuPkg::ramAddrT wAddr,
    input  ppuPkg::ramWordT wData,
    input  ppuPkg::ramAddrT cpuRAddr,
    output ppuPkg::ramWordT cpuRData,
    input  ppuPkg::ramAddrT nameRAddr,
    output ppuPkg::ramWordT nameRData,
    input  ppuPkg::ramAddrT attrRAddr,
    output ppuPkg::ramWordT attrRData
);

    ppuPkg::ramWordT mem [ppuPkg::RAM_WORDS];

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_sel) begin
        for (int k = 0; k < ppuPkg::BYTES_PER_WORD; k++) begin
            if (we[k]) begin
                mem[wAddr][8*k +: 8] <= wData[8*k +: 8];   // only enabled lanes change
            end
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read ports
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_sel) begin
        cpuRData <= mem[cpuRAddr];   // a colliding write shows up one read later
    end

    always_ff @(posedge clk_sel) begin
        nameRData <= mem[nameRAddr];
    end

    always_ff @(posedge clk_sel) begin
        attrRData <= mem[attrRAddr];
    end

endmodule

//--- source/loaderQueue.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Loader queue
// Four-entry FIFO of RAM write requests for one loader stream. Every
// entry that leaves is reported back to the loader as one credit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module loaderQueue (
    input  logic            clk_sel,
    input  logic            reset,
    input  logic            pushValid,
    input  ppuPkg::byteEnT  pushWe,
    input  ppuPkg::ramAddrT pushAddr,
    input  ppuPkg::ramWordT pushData,
    output logic            headValid,
    output ppuPkg::byteEnT  headWe,
    output ppuPkg::ramAddrT headAddr,
    output ppuPkg::ramWordT headData,
    input  logic            pop,
    output logic            credit
);

    ppuPkg::byteEnT   weMem   [ppuPkg::LOADER_CREDITS];
    ppuPkg::ramAddrT  addrMem [ppuPkg::LOADER_CREDITS];
    ppuPkg::ramWordT  dataMem [ppuPkg::LOADER_CREDITS];
    ppuPkg::queuePtrT wrPtr;
    ppuPkg::queuePtrT rdPtr;
    ppuPkg::queueCntT count;
    logic             doPush;
    logic             doPop;

    assign doPop  = pop && headValid;
    assign doPush = pushValid && (count != ppuPkg::queueCntT'(ppuPkg::LOADER_CREDITS));

    always_ff @(posedge clk_sel) begin
        if (doPush) begin
            weMem[wrPtr]   <= pushWe;
            addrMem[wrPtr] <= pushAddr;
            dataMem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk_sel) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;   // depth is a power of two so it wraps by itself
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign headValid = (count != '0);
    assign headWe    = weMem[rdPtr];
    assign headAddr  = addrMem[rdPtr];
    assign headData  = dataMem[rdPtr];
    assign credit    = doPop;   // same cycle the word is written to the RAM

endmodule

//--- source/writeArbiter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write arbiter
// Fixed priority selector for the single RAM write port:
// CPU first, then the name queue head, then the attribute queue head
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module writeArbiter (
    input  ppuPkg::byteEnT  cpuWe,
    input  ppuPkg::ramAddrT cpuWAddr,
    input  ppuPkg::ramWordT cpuWData,
    input  logic            nameValid,
    input  ppuPkg::byteEnT  nameWe,
    input  ppuPkg::ramAddrT nameAddr,
    input  ppuPkg::ramWordT nameData,
    input  logic            attrValid,
    input  ppuPkg::byteEnT  attrWe,
    input  ppuPkg::ramAddrT attrAddr,
    input  ppuPkg::ramWordT attrData,
    output logic            namePop,
    output logic            attrPop,
    output ppuPkg::byteEnT  we,
    output ppuPkg::ramAddrT wAddr,
    output ppuPkg::ramWordT wData
);

    logic cpuWins;

    assign cpuWins = (cpuWe != '0);

    // a losing queue keeps its head and simply tries again next cycle
    assign namePop = nameValid && !cpuWins;
    assign attrPop = attrValid && !cpuWins && !nameValid;

    always_comb begin
        we    = '0;
        wAddr = cpuWAddr;
        wData = cpuWData;
        if (cpuWins) begin
            we = cpuWe;
        end else if (nameValid) begin
            we    = nameWe;
            wAddr = nameAddr;
            wData = nameData;
        end else if (attrValid) begin
            we    = attrWe;
            wAddr = attrAddr;
            wData = attrData;
        end
    end

endmodule

//--- source/tileFetcher.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile fetcher
// Walks the 32 columns of one tile row, reading the name and attribute
// words together, and emits tile index and palette under credit control
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tileFetcher (
    input  logic            clk_sel,
    input  logic            reset,
    input  logic            fetchStart,
    input  ppuPkg::tileRowT fetchRow,
    output logic            fetchBusy,
    output ppuPkg::ramAddrT nameRAddr,
    input  ppuPkg::ramWordT nameRData,
    output ppuPkg::ramAddrT attrRAddr,
    input  ppuPkg::ramWordT attrRData,
    output logic            tileValid,
    output ppuPkg::tileIdxT tileIndex,
    output ppuPkg::paletteT tilePalette,
    output ppuPkg::tileColT tileCol,
    input  logic            tileCredit
);

    ppuPkg::fetchStateT state;
    ppuPkg::tileRowT    rowQ;
    ppuPkg::tileColT    issueCol;
    logic               issueDone;
    ppuPkg::creditCntT  credits;
    logic               issue;
    logic               lastOut;

    logic               s1Valid;
    ppuPkg::tileColT    s1Col;
    ppuPkg::laneT       s1NameLane;
    ppuPkg::laneT       s1AttrLane;
    logic [1:0]         s1Quad;
    logic [7:0]         attrByte;
    ppuPkg::tileIdxT    pickIndex;
    ppuPkg::paletteT    pickPalette;

    assign issue     = (state == ppuPkg::walk) && !issueDone && (credits != '0);
    assign lastOut   = tileValid && (tileCol == '1);   // column 31 is all ones
    assign fetchBusy = (state == ppuPkg::walk);

    // name word is row*8 + col/4, attribute word is ((row/4)*8 + col/4) / 4
    assign nameRAddr = ppuPkg::NAME_BASE + ppuPkg::ramAddrT'({rowQ, issueCol[4:2]});
    assign attrRAddr = ppuPkg::ATTR_BASE + ppuPkg::ramAddrT'({rowQ[4:2], issueCol[4]});

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // row walk and credits
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_sel) begin
        if (reset) begin
            state     <= ppuPkg::idle;
            rowQ      <= '0;
            issueCol  <= '0;
            issueDone <= 1'b0;
        end else begin
            case (state)
                ppuPkg::idle: begin
                    if (fetchStart) begin
                        state     <= ppuPkg::walk;
                        rowQ      <= fetchRow;
                        issueCol  <= '0;
                        issueDone <= 1'b0;
                    end
                end
                ppuPkg::walk: begin
                    if (issue) begin
                        issueCol <= issueCol + 1'b1;
                        if (issueCol == '1) begin
                            issueDone <= 1'b1;
                        end
                    end
                    if (lastOut) begin
                        state <= ppuPkg::idle;   // busy drops after the last tile is out
                    end
                end
                default: state <= ppuPkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk_sel) begin
        if (reset) begin
            credits <= ppuPkg::creditCntT'(ppuPkg::TILE_CREDITS);
        end else begin
            case ({issue, tileCredit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;   // both or neither cancel out
            endcase
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read pipeline and output stage
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_sel) begin
        if (reset) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= issue;   // lines up with the RAM read data
        end
    end

    always_ff @(posedge clk_sel) begin
        s1Col      <= issueCol;
        s1NameLane <= issueCol[1:0];
        s1AttrLane <= issueCol[3:2];
        s1Quad     <= {rowQ[1], issueCol[1]};
    end

    always_comb begin
        pickIndex   = nameRData[{s1NameLane, 3'b000} +: 8];
        attrByte    = attrRData[{s1AttrLane, 3'b000} +: 8];
        pickPalette = attrByte[{s1Quad, 1'b0} +: 2];
    end

    always_ff @(posedge clk_sel) begin
        if (reset) begin
            tileValid <= 1'b0;
        end else begin
            tileValid <= s1Valid;
        end
    end

    always_ff @(posedge clk_sel) begin
        if (s1Valid) begin
            tileIndex   <= pickIndex;
            tilePalette <= pickPalette;
            tileCol     <= s1Col;
        end
    end

endmodule

//--- source/ppuNameTable.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PPU name table store
// Top level joining the loader queues, write arbiter, RAM and tile fetcher
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ppuNameTable (
    input  logic            clk_sel,
    input  logic            reset,
    input  ppuPkg::byteEnT  cpuWe,
    input  ppuPkg::ramAddrT cpuWAddr,
    input  ppuPkg::ramWordT cpuWData,
    input  ppuPkg::ramAddrT cpuRAddr,
    output ppuPkg::ramWordT cpuRData,
    input  logic            nameValid,
    input  ppuPkg::byteEnT  nameWe,
    input  ppuPkg::ramAddrT nameAddr,
    input  ppuPkg::ramWordT nameData,
    output logic            nameCredit,
    input  logic            attrValid,
    input  ppuPkg::byteEnT  attrWe,
    input  ppuPkg::ramAddrT attrAddr,
    input  ppuPkg::ramWordT attrData,
    output logic            attrCredit,
    input  logic            fetchStart,
    input  ppuPkg::tileRowT fetchRow,
    output logic            fetchBusy,
    output logic            tileValid,
    output ppuPkg::tileIdxT tileIndex,
    output ppuPkg::paletteT tilePalette,
    output ppuPkg::tileColT tileCol,
    input  logic            tileCredit
);

    logic            nameHeadValid;
    ppuPkg::byteEnT  nameHeadWe;
    ppuPkg::ramAddrT nameHeadAddr;
    ppuPkg::ramWordT nameHeadData;
    logic            namePop;
    logic            attrHeadValid;
    ppuPkg::byteEnT  attrHeadWe;
    ppuPkg::ramAddrT attrHeadAddr;
    ppuPkg::ramWordT attrHeadData;
    logic            attrPop;
    ppuPkg::byteEnT  ramWe;
    ppuPkg::ramAddrT ramWAddr;
    ppuPkg::ramWordT ramWData;
    ppuPkg::ramAddrT nameRAddr;
    ppuPkg::ramWordT nameRData;
    ppuPkg::ramAddrT attrRAddr;
    ppuPkg::ramWordT attrRData;

    loaderQueue nameQueue (
        .clk_sel(clk_sel), .reset(reset),
        .pushValid(nameValid), .pushWe(nameWe), .pushAddr(nameAddr), .pushData(nameData),
        .headValid(nameHeadValid), .headWe(nameHeadWe),
        .headAddr(nameHeadAddr), .headData(nameHeadData),
        .pop(namePop), .credit(nameCredit)
    );

    loaderQueue attrQueue (
        .clk_sel(clk_sel), .reset(reset),
        .pushValid(attrValid), .pushWe(attrWe), .pushAddr(attrAddr), .pushData(attrData),
        .headValid(attrHeadValid), .headWe(attrHeadWe),
        .headAddr(attrHeadAddr), .headData(attrHeadData),
        .pop(attrPop), .credit(attrCredit)
    );

    writeArbiter arbiter (
        .cpuWe(cpuWe), .cpuWAddr(cpuWAddr), .cpuWData(cpuWData),
        .nameValid(nameHeadValid), .nameWe(nameHeadWe),
        .nameAddr(nameHeadAddr), .nameData(nameHeadData),
        .attrValid(attrHeadValid), .attrWe(attrHeadWe),
        .attrAddr(attrHeadAddr), .attrData(attrHeadData),
        .namePop(namePop), .attrPop(attrPop),
        .we(ramWe), .wAddr(ramWAddr), .wData(ramWData)
    );

    nameTableRam ram (
        .clk_sel(clk_sel),
        .we(ramWe), .wAddr(ramWAddr), .wData(ramWData),
        .cpuRAddr(cpuRAddr), .cpuRData(cpuRData),
        .nameRAddr(nameRAddr), .nameRData(nameRData),
        .attrRAddr(attrRAddr), .attrRData(attrRData)
    );

    tileFetcher fetcher (
        .clk_sel(clk_sel), .reset(reset),
        .fetchStart(fetchStart), .fetchRow(fetchRow), .fetchBusy(fetchBusy),
        .nameRAddr(nameRAddr), .nameRData(nameRData),
        .attrRAddr(attrRAddr), .attrRData(attrRData),
        .tileValid(tileValid), .tileIndex(tileIndex),
        .tilePalette(tilePalette), .tileCol(tileCol),
        .tileCredit(tileCredit)
    );

endmodule

//--- tb/tbModel.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Name table reference model
// Byte-level copy of the RAM plus the tile index and palette rules
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [7:0] refMem [ppuPkg::RAM_WORDS * 4];   // byte 4*word + lane

function automatic void applyWrite(input ppuPkg::byteEnT we, input ppuPkg::ramAddrT addr,
                                   input ppuPkg::ramWordT data);
    int k;
    for (k = 0; k < 4; k++) begin
        if (we[k]) begin
            refMem[int'(addr) * 4 + k] = data[8*k +: 8];
        end
    end
endfunction

function automatic ppuPkg::ramWordT refWord(input int addr);
    int base;
    base = addr * 4;
    return {refMem[base + 3], refMem[base + 2], refMem[base + 1], refMem[base]};
endfunction

// tile (r, c) is byte c mod 4 of name word r*8 + c/4
function automatic ppuPkg::tileIdxT expTileIndex(input int r, input int c);
    return refMem[(int'(ppuPkg::NAME_BASE) + r * 8 + c / 4) * 4 + c % 4];
endfunction

function automatic ppuPkg::paletteT expPalette(input int r, input int c);
    int         n;
    int         q;
    logic [7:0] attrByte;
    n        = (r / 4) * 8 + c / 4;
    attrByte = refMem[(int'(ppuPkg::ATTR_BASE) + n / 4) * 4 + n % 4];
    q        = 2 * ((r / 2) % 2) + (c / 2) % 2;   // quadrant inside the 4x4 tile block
    return attrByte[2 * q +: 2];
endfunction

`endif

//--- tb/ppuNameTableTb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PPU name table testbench
// Drives CPU, loader and fetch traffic and checks the RAM contents and
// the tile stream against a byte-level reference model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ppuNameTableTb;

    logic            clk_sel;
    logic            reset;
    ppuPkg::byteEnT  cpuWe;
    ppuPkg::ramAddrT cpuWAddr;
    ppuPkg::ramWordT cpuWData;
    ppuPkg::ramAddrT cpuRAddr;
    ppuPkg::ramWordT cpuRData;
    logic            nameValid;
    ppuPkg::byteEnT  nameWe;
    ppuPkg::ramAddrT nameAddr;
    ppuPkg::ramWordT nameData;
    logic            nameCredit;
    logic            attrValid;
    ppuPkg::byteEnT  attrWe;
    ppuPkg::ramAddrT attrAddr;
    ppuPkg::ramWordT attrData;
    logic            attrCredit;
    logic            fetchStart;
    ppuPkg::tileRowT fetchRow;
    logic            fetchBusy;
    logic            tileValid;
    ppuPkg::tileIdxT tileIndex;
    ppuPkg::paletteT tilePalette;
    ppuPkg::tileColT tileCol;
    logic            tileCredit;

    int          errors = 0;
    int          nameCred;                 // credits held by each loader
    int          attrCred;
    integer      seed;
    logic [44:0] namePend [$];             // {we, addr, data} waiting in each queue
    logic [44:0] attrPend [$];
    logic [44:0] headEntry;
    logic        expName;
    logic        expAttr;

    `include "tbModel.svh"

    ppuNameTable UUT (.*);

    initial begin
        clk_sel = 1'b0;
        forever #50 clk_sel = ~clk_sel;
    end

    task automatic reportMismatch(input string msg);
        errors++;
        $display("MISMATCH @%0t: %s", $time, msg);
    endtask

    task automatic reportFailure(input string msg);
        errors++;
        $display("ERROR @%0t: %s", $time, msg);
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port model, applied in arbiter order at every clock edge
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk_sel) begin
        if (reset) begin
            namePend.delete();
            attrPend.delete();
        end else begin
            expName = 1'b0;
            expAttr = 1'b0;
            if (cpuWe != '0) begin
                applyWrite(cpuWe, cpuWAddr, cpuWData);
            end else if (namePend.size() > 0) begin
                headEntry = namePend.pop_front();
                applyWrite(headEntry[44:41], headEntry[40:32], headEntry[31:0]);
                expName = 1'b1;
            end else if (attrPend.size() > 0) begin
                headEntry = attrPend.pop_front();
                applyWrite(headEntry[44:41], headEntry[40:32], headEntry[31:0]);
                expAttr = 1'b1;
            end
            assert (nameCredit === expName) else
                reportMismatch($sformatf("nameCredit %b, expected %b", nameCredit, expName));
            assert (attrCredit === expAttr) else
                reportMismatch($sformatf("attrCredit %b, expected %b", attrCredit, expAttr));
            if (nameCredit) begin
                nameCred++;
            end
            if (attrCredit) begin
                attrCred++;
            end
            if (nameValid) begin
                namePend.push_back({nameWe, nameAddr, nameData});   // usable from the next edge
            end
            if (attrValid) begin
                attrPend.push_back({attrWe, attrAddr, attrData});
            end
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus tasks, each entered and left on a falling edge
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic cpuWrite(input ppuPkg::byteEnT we, input int addr, input ppuPkg::ramWordT d);
        cpuWe    = we;
        cpuWAddr = ppuPkg::ramAddrT'(addr);
        cpuWData = d;
        @(negedge clk_sel);
        cpuWe = '0;
    endtask

    task automatic readCheck(input int addr);
        ppuPkg::ramWordT expWord;
        cpuRAddr = ppuPkg::ramAddrT'(addr);
        @(negedge clk_sel);
        expWord = refWord(addr);
        assert (cpuRData === expWord) else
            reportMismatch($sformatf("CPU read of word %0d gave %h, expected %h",
                                     addr, cpuRData, expWord));
    endtask

    task automatic waitCreditsHome();
        int cycles;
        cycles = 0;
        while ((nameCred != ppuPkg::LOADER_CREDITS || attrCred != ppuPkg::LOADER_CREDITS)
               && cycles < 50) begin
            @(negedge clk_sel);
            cycles++;
        end
        if (nameCred != ppuPkg::LOADER_CREDITS || attrCred != ppuPkg::LOADER_CREDITS) begin
            reportFailure("timeout waiting for the loader credits to come back");
        end
    endtask

    task automatic writeAndReadBack();
        int i;
        for (i = 0; i < 8; i++) begin
            cpuWrite(4'hF, 300 + i, $random(seed));
        end
        for (i = 0; i < 8; i++) begin
            // at least one lane stays untouched
            cpuWrite(ppuPkg::byteEnT'($random(seed)) & ~ppuPkg::byteEnT'(1 << (i % 4)),
                     300 + i, $random(seed));
            readCheck(300 + i);
        end
    endtask

    task automatic loadRegions();
        int nameIdx;
        int attrIdx;
        int cycles;
        nameIdx = 0;
        attrIdx = 0;
        cycles  = 0;
        while ((nameIdx < 240 || attrIdx < 16) && cycles < 2000) begin
            nameValid = 1'b0;
            attrValid = 1'b0;
            if (nameIdx < 240 && nameCred > 0 && ($random(seed) & 3) != 0) begin
                nameValid = 1'b1;
                nameWe    = 4'hF;
                nameAddr  = ppuPkg::ramAddrT'(int'(ppuPkg::NAME_BASE) + nameIdx);
                nameData  = $random(seed);
                nameCred--;
                nameIdx++;
            end
            if (attrIdx < 16 && attrCred > 0 && ($random(seed) & 3) != 0) begin
                attrValid = 1'b1;
                attrWe    = 4'hF;
                attrAddr  = ppuPkg::ramAddrT'(int'(ppuPkg::ATTR_BASE) + attrIdx);
                attrData  = $random(seed);
                attrCred--;
                attrIdx++;
            end
            @(negedge clk_sel);
            cycles++;
        end
        nameValid = 1'b0;
        attrValid = 1'b0;
        if (nameIdx < 240 || attrIdx < 16) begin
            reportFailure("timeout while streaming the loader words");
        end
        waitCreditsHome();
        for (nameIdx = 0; nameIdx < 240; nameIdx++) begin
            readCheck(int'(ppuPkg::NAME_BASE) + nameIdx);
        end
        for (attrIdx = 0; attrIdx < 16; attrIdx++) begin
            readCheck(int'(ppuPkg::ATTR_BASE) + attrIdx);
        end
    endtask

    task automatic cpuStallsLoaders();
        int i;
        for (i = 0; i < 12; i++) begin
            cpuWe     = ppuPkg::byteEnT'($random(seed)) | 4'h1;
            cpuWAddr  = ppuPkg::ramAddrT'((i < 6) ? 8 + i % 4 : 256 + i % 4);
            cpuWData  = $random(seed);
            nameValid = 1'b0;
            attrValid = 1'b0;
            if (i < 4 && nameCred > 0) begin
                nameValid = 1'b1;
                nameWe    = 4'hF;
                nameAddr  = ppuPkg::ramAddrT'(8 + i);   // same words the CPU is hitting
                nameData  = $random(seed);
                nameCred--;
            end
            if (i < 4 && attrCred > 0) begin
                attrValid = 1'b1;
                attrWe    = 4'hF;
                attrAddr  = ppuPkg::ramAddrT'(256 + i);
                attrData  = $random(seed);
                attrCred--;
            end
            @(negedge clk_sel);
        end
        cpuWe     = '0;
        nameValid = 1'b0;
        attrValid = 1'b0;
        assert (nameCred == 0 && attrCred == 0) else
            reportMismatch("a loader credit came back while the CPU held the write port");
        waitCreditsHome();
        for (i = 0; i < 4; i++) begin
            readCheck(8 + i);
            readCheck(256 + i);
        end
    endtask

    task automatic fetchRowCheck(input int row, input int holdCycles, input int gap);
        int col;
        int owed;
        int cycles;
        int doneAt;
        col        = 0;
        owed       = 0;
        cycles     = 0;
        doneAt     = -1;
        fetchRow   = ppuPkg::tileRowT'(row);
        fetchStart = 1'b1;
        @(negedge clk_sel);
        fetchStart = 1'b0;
        assert (fetchBusy) else
            reportMismatch($sformatf("fetchBusy did not rise for row %0d", row));
        while ((col < 32 || owed > 0 || fetchBusy) && cycles < 400) begin
            if (col < 32) begin
                assert (fetchBusy) else
                    reportMismatch($sformatf("fetchBusy low before column %0d of row %0d",
                                             col, row));
            end
            if (doneAt >= 0 && cycles == doneAt + 1) begin
                assert (!fetchBusy) else
                    reportMismatch($sformatf("fetchBusy still high after row %0d ended", row));
            end
            if (tileValid) begin
                assert (col < 32) else
                    reportMismatch($sformatf("extra tile after column 31 in row %0d", row));
                if (col < 32) begin
                    assert (tileCol === ppuPkg::tileColT'(col)) else
                        reportMismatch($sformatf("row %0d tileCol %0d, expected %0d",
                                                 row, tileCol, col));
                    assert (tileIndex === expTileIndex(row, col)) else
                        reportMismatch($sformatf("row %0d col %0d tileIndex %h, expected %h",
                                                 row, col, tileIndex, expTileIndex(row, col)));
                    assert (tilePalette === expPalette(row, col)) else
                        reportMismatch($sformatf("row %0d col %0d tilePalette %0d, expected %0d",
                                                 row, col, tilePalette, expPalette(row, col)));
                end
                col++;
                owed++;
                if (col == 32) begin
                    doneAt = cycles;
                end
            end
            assert (owed <= ppuPkg::TILE_CREDITS) else
                reportMismatch($sformatf("%0d tiles outstanding beyond the credit limit", owed));
            if (holdCycles > 0 && cycles == holdCycles) begin
                assert (col == ppuPkg::TILE_CREDITS) else
                    reportMismatch($sformatf("%0d tiles arrived with credits held, expected %0d",
                                             col, ppuPkg::TILE_CREDITS));
            end
            if (owed > 0 && cycles >= holdCycles && (cycles % gap) == 0) begin
                tileCredit = 1'b1;   // one credit back per pulse
                owed--;
            end else begin
                tileCredit = 1'b0;
            end
            @(negedge clk_sel);
            cycles++;
        end
        tileCredit = 1'b0;
        if (col < 32 || owed > 0 || fetchBusy) begin
            reportFailure($sformatf("timeout while fetching row %0d", row));
        end
        assert (col == 32) else
            reportMismatch($sformatf("row %0d gave %0d tiles, expected 32", row, col));
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        seed       = 4;
        reset      = 1'b1;
        cpuWe      = '0;
        cpuWAddr   = '0;
        cpuWData   = '0;
        cpuRAddr   = '0;
        nameValid  = 1'b0;
        nameWe     = '0;
        nameAddr   = '0;
        nameData   = '0;
        attrValid  = 1'b0;
        attrWe     = '0;
        attrAddr   = '0;
        attrData   = '0;
        fetchStart = 1'b0;
        fetchRow   = '0;
        tileCredit = 1'b0;
        nameCred   = ppuPkg::LOADER_CREDITS;
        attrCred   = ppuPkg::LOADER_CREDITS;
        repeat (2) @(posedge clk_sel);
        @(negedge clk_sel);
        reset = 1'b0;
        @(negedge clk_sel);
        assert (!fetchBusy && !tileValid && !nameCredit && !attrCredit) else
            reportMismatch("outputs not idle after reset");

        writeAndReadBack();
        loadRegions();
        cpuStallsLoaders();
        fetchRowCheck(0, 0, 1);
        fetchRowCheck(3, 0, 1);
        fetchRowCheck(17, 0, 1);
        fetchRowCheck(29, 0, 1);
        fetchRowCheck(14, 20, 3);   // consumer holds its credits, then trickles them back

        $display("run finished with %0d errors", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- ppuNameTable.f
+incdir+tb
source/ppuPkg.sv
source/nameTableRam.sv
source/loaderQueue.sv
source/writeArbiter.sv
source/tileFetcher.sv
source/ppuNameTable.sv
tb/ppuNameTableTb.sv

//--- runSim.sh
#!/bin/sh
# compile the name table testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f ppuNameTable.f --top-module ppuNameTableTb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/VppuNameTableTb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
